//--- pio_consts.svh
`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

`define PIO_MEM_DEPTH 32
`define PIO_ADDR_W    5
`define PIO_NUM_SM    2
`define PIO_INSTR_W   16
`define PIO_DATA_W    32
`define PIO_PINS_W    8

// Instruction fields from the top down
`define PIO_OP_W      3
`define PIO_DELAY_W   5
`define PIO_CTL_W     3
`define PIO_ARG_W     5

`endif

//--- pio_pkg.sv
package pio_pkg;

  `include "pio_consts.svh"

  typedef enum logic [`PIO_OP_W-1:0] {
    OP_JMP      = 3'd0,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_MOV      = 3'd5,
    OP_SET      = 3'd7
  } pio_op_e;

  typedef enum logic [`PIO_CTL_W-1:0] {
    COND_ALWAYS = 3'd0,
    COND_X_ZERO = 3'd1,
    COND_X_DEC  = 3'd2, // X nonzero, X post-decrement
    COND_Y_ZERO = 3'd3,
    COND_Y_DEC  = 3'd4, // Y nonzero, Y post-decrement
    COND_X_NE_Y = 3'd5
  } pio_cond_e;

  // Shared by sources and destinations
  typedef enum logic [2:0] {
    DST_PINS = 3'd0,
    DST_X    = 3'd1,
    DST_Y    = 3'd2,
    DST_NULL = 3'd3,
    DST_ISR  = 3'd6,
    DST_OSR  = 3'd7
  } pio_dest_e;

  typedef enum logic [1:0] {FETCH, EXEC, DELAY} pio_state_e;

  typedef struct packed {
    pio_op_e                 op;
    logic [`PIO_DELAY_W-1:0] delay;
    logic [`PIO_CTL_W-1:0]   ctl;   // Condition, source or destination
    logic [`PIO_ARG_W-1:0]   arg;   // Address, data, bit count or MOV control
  } pio_instr_t;

endpackage

//--- pio_fetch_if.sv
`timescale 1ns/10ps
`include "pio_consts.svh"

interface pio_fetch_if import pio_pkg::*; ();

  logic                   req;   // Held with addr until granted
  logic [`PIO_ADDR_W-1:0] addr;
  logic                   gnt;
  pio_instr_t             instr; // Valid the cycle after gnt

  modport requester (
    output req,
    output addr,
    input  gnt,
    input  instr
  );

  modport arbiter (
    input  req,
    input  addr,
    output gnt,
    output instr
  );

endinterface

//--- instr_mem.sv
`timescale 1ns/10ps
`include "pio_consts.svh"

module instr_mem import pio_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   we,
  input  logic [`PIO_ADDR_W-1:0] waddr,
  input  pio_instr_t             wdata,
  input  logic [`PIO_ADDR_W-1:0] raddr,
  output pio_instr_t             rdata
);

  pio_instr_t mem_q [`PIO_MEM_DEPTH];

  // Program load port
  always_ff @(posedge clk) begin
    if (we) begin
      mem_q[waddr] <= wdata;
    end
  end

  // Zero word decodes as JMP 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem_q[raddr];
    end
  end

endmodule

//--- fetch_arbiter.sv
`timescale 1ns/10ps
`include "pio_consts.svh"

module fetch_arbiter import pio_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  pio_fetch_if.arbiter           port0,
  pio_fetch_if.arbiter           port1,
  output logic [`PIO_ADDR_W-1:0] mem_addr,
  input  pio_instr_t             mem_data
);

  logic last_q;   // Machine granted most recently, also selects read data
  logic rd_vld_q; // Memory read in flight
  logic any_gnt;

  // Contention goes to the machine not granted last
  assign port0.gnt = port0.req && (!port1.req || last_q);
  assign port1.gnt = port1.req && (!port0.req || !last_q);
  assign any_gnt   = port0.gnt || port1.gnt;

  assign mem_addr = port1.gnt ? port1.addr : port0.addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q   <= 1'b0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= any_gnt;
      if (any_gnt) begin
        last_q <= port1.gnt;
      end
    end
  end

  // Read data goes back only to the machine that asked for it
  assign port0.instr = (rd_vld_q && !last_q) ? mem_data : '0;
  assign port1.instr = (rd_vld_q && last_q) ? mem_data : '0;

endmodule

//--- pio_sm.sv
`timescale 1ns/10ps
`include "pio_consts.svh"

module pio_sm import pio_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en,
  input  logic [`PIO_ADDR_W-1:0] wrap_bottom,
  input  logic [`PIO_ADDR_W-1:0] wrap_top,
  input  logic [`PIO_DATA_W-1:0] tx_data,
  input  logic                   tx_empty,
  input  logic                   rx_full,
  pio_fetch_if.requester         fetch,
  output logic                   pull,
  output logic                   push,
  output logic [`PIO_DATA_W-1:0] rx_data,
  output logic [`PIO_PINS_W-1:0] pins,
  output logic [`PIO_ADDR_W-1:0] pc
);

  pio_state_e              state_q;
  logic [`PIO_ADDR_W-1:0]  pc_q;
  logic                    pc_loaded_q; // pc follows wrap_bottom until the first update
  pio_instr_t              instr_q;
  logic                    fresh_q;     // First EXEC cycle
  logic [`PIO_DELAY_W-1:0] dly_q;
  logic [`PIO_DATA_W-1:0]  x_q;
  logic [`PIO_DATA_W-1:0]  y_q;
  logic [`PIO_DATA_W-1:0]  isr_q;
  logic [`PIO_DATA_W-1:0]  osr_q;

  pio_instr_t              cur;
  logic                    stall;
  logic                    done;
  logic                    jmp_taken;
  logic [5:0]              bit_n;
  logic [`PIO_DATA_W-1:0]  mask;
  logic [`PIO_DATA_W-1:0]  src_val;
  logic [`PIO_DATA_W-1:0]  mov_val;
  logic [`PIO_DATA_W-1:0]  out_val;
  logic [`PIO_DATA_W-1:0]  set_val;
  logic [`PIO_ADDR_W-1:0]  pc_next;

  assign pc      = pc_loaded_q ? pc_q : wrap_bottom;
  assign cur     = fresh_q ? fetch.instr : instr_q; // Fetch port only valid right after grant
  assign rx_data = isr_q;

  assign fetch.req  = en && (state_q == FETCH);
  assign fetch.addr = pc;

  // Bit count of 0 means a full word
  assign bit_n   = (cur.arg == '0) ? 6'd32 : {1'b0, cur.arg};
  assign mask    = (`PIO_DATA_W'(1) << bit_n) - 1'b1;
  assign out_val = osr_q & mask;
  assign mov_val = src_val ^ {`PIO_DATA_W{cur.arg[3]}};
  assign set_val = {{(`PIO_DATA_W-`PIO_ARG_W){1'b0}}, cur.arg};

  // MOV takes its source from arg, IN from ctl
  always_comb begin
    case (pio_dest_e'((cur.op == OP_MOV) ? cur.arg[2:0] : cur.ctl))
      DST_X:   src_val = x_q;
      DST_Y:   src_val = y_q;
      DST_ISR: src_val = isr_q;
      DST_OSR: src_val = osr_q;
      default: src_val = '0;
    endcase
  end

  always_comb begin
    stall     = 1'b0;
    jmp_taken = 1'b0;
    case (cur.op)
      OP_PUSHPULL: stall = cur.ctl[2] ? tx_empty : rx_full;
      OP_JMP: begin
        case (pio_cond_e'(cur.ctl))
          COND_ALWAYS: jmp_taken = 1'b1;
          COND_X_ZERO: jmp_taken = (x_q == '0);
          COND_X_DEC:  jmp_taken = (x_q != '0);
          COND_Y_ZERO: jmp_taken = (y_q == '0);
          COND_Y_DEC:  jmp_taken = (y_q != '0);
          COND_X_NE_Y: jmp_taken = (x_q != y_q);
          default:     jmp_taken = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  assign done = (state_q == EXEC) && !stall;
  assign pull = done && (cur.op == OP_PUSHPULL) && cur.ctl[2];
  assign push = done && (cur.op == OP_PUSHPULL) && !cur.ctl[2];

  always_comb begin
    if (jmp_taken) begin
      pc_next = cur.arg;
    end else if (pc == wrap_top) begin
      pc_next = wrap_bottom;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FETCH;
      pc_q        <= '0;
      pc_loaded_q <= 1'b0;
      fresh_q     <= 1'b0;
      dly_q       <= '0;
    end else begin
      fresh_q <= 1'b0;
      case (state_q)
        FETCH: begin
          if (fetch.req && fetch.gnt) begin
            state_q <= EXEC;
            fresh_q <= 1'b1;
          end
        end
        EXEC: begin
          if (done) begin
            pc_q        <= pc_next;
            pc_loaded_q <= 1'b1;
            dly_q       <= cur.delay;
            state_q     <= (cur.delay != '0) ? DELAY : FETCH;
          end
        end
        DELAY: begin
          dly_q <= dly_q - 1'b1;
          if (dly_q == `PIO_DELAY_W'(1)) begin
            state_q <= FETCH;
          end
        end
        default: state_q <= FETCH;
      endcase
    end
  end

  // Holds the instruction over a stall
  always_ff @(posedge clk) begin
    if (state_q == EXEC) begin
      instr_q <= cur;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_q   <= '0;
      y_q   <= '0;
      isr_q <= '0;
      osr_q <= '0;
      pins  <= '0;
    end else if (done) begin
      case (cur.op)
        OP_JMP: begin
          if (cur.ctl == COND_X_DEC) x_q <= x_q - 1'b1;
          if (cur.ctl == COND_Y_DEC) y_q <= y_q - 1'b1;
        end
        OP_IN: isr_q <= (isr_q << bit_n) | (src_val & mask);
        OP_OUT: begin
          osr_q <= osr_q >> bit_n;
          case (pio_dest_e'(cur.ctl))
            DST_PINS: pins <= out_val[`PIO_PINS_W-1:0];
            DST_X:    x_q  <= out_val;
            DST_Y:    y_q  <= out_val;
            default: ;
          endcase
        end
        OP_PUSHPULL: begin
          if (cur.ctl[2]) begin
            osr_q <= tx_data;
          end else begin
            isr_q <= '0; // rx_data took the ISR this cycle
          end
        end
        OP_MOV: begin
          case (pio_dest_e'(cur.ctl))
            DST_X:   x_q   <= mov_val;
            DST_Y:   y_q   <= mov_val;
            DST_ISR: isr_q <= mov_val;
            DST_OSR: osr_q <= mov_val;
            default: ;
          endcase
        end
        OP_SET: begin
          case (pio_dest_e'(cur.ctl))
            DST_PINS: pins <= set_val[`PIO_PINS_W-1:0];
            DST_X:    x_q  <= set_val;
            DST_Y:    y_q  <= set_val;
            default: ;
          endcase
        end
        default: ; // Opcodes 1 and 6 do nothing
      endcase
    end
  end

endmodule

//--- pio_block.sv
`timescale 1ns/10ps
`include "pio_consts.svh"

module pio_block import pio_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`PIO_NUM_SM-1:0]                en,
  input  logic [`PIO_NUM_SM*`PIO_ADDR_W-1:0]    wrap_bottom,
  input  logic [`PIO_NUM_SM*`PIO_ADDR_W-1:0]    wrap_top,
  input  logic                                  prog_we,
  input  logic [`PIO_ADDR_W-1:0]                prog_addr,
  input  logic [`PIO_INSTR_W-1:0]               prog_data,
  input  logic [`PIO_NUM_SM*`PIO_DATA_W-1:0]    tx_data,
  input  logic [`PIO_NUM_SM-1:0]                tx_empty,
  input  logic [`PIO_NUM_SM-1:0]                rx_full,
  output logic [`PIO_NUM_SM-1:0]                pull,
  output logic [`PIO_NUM_SM-1:0]                push,
  output logic [`PIO_NUM_SM*`PIO_DATA_W-1:0]    rx_data,
  output logic [`PIO_NUM_SM*`PIO_PINS_W-1:0]    pins,
  output logic [`PIO_NUM_SM*`PIO_ADDR_W-1:0]    pc
);

  pio_fetch_if fetch_if [`PIO_NUM_SM] ();

  logic [`PIO_ADDR_W-1:0] mem_raddr;
  pio_instr_t             mem_rdata;

  instr_mem u_instr_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  fetch_arbiter u_fetch_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .port0    (fetch_if[0]),
    .port1    (fetch_if[1]),
    .mem_addr (mem_raddr),
    .mem_data (mem_rdata)
  );

  for (genvar g = 0; g < `PIO_NUM_SM; g++) begin : g_sm
    pio_sm u_sm (
      .clk         (clk),
      .rst_n       (rst_n),
      .en          (en[g]),
      .wrap_bottom (wrap_bottom[g*`PIO_ADDR_W +: `PIO_ADDR_W]),
      .wrap_top    (wrap_top[g*`PIO_ADDR_W +: `PIO_ADDR_W]),
      .tx_data     (tx_data[g*`PIO_DATA_W +: `PIO_DATA_W]),
      .tx_empty    (tx_empty[g]),
      .rx_full     (rx_full[g]),
      .fetch       (fetch_if[g]),
      .pull        (pull[g]),
      .push        (push[g]),
      .rx_data     (rx_data[g*`PIO_DATA_W +: `PIO_DATA_W]),
      .pins        (pins[g*`PIO_PINS_W +: `PIO_PINS_W]),
      .pc          (pc[g*`PIO_ADDR_W +: `PIO_ADDR_W])
    );
  end

endmodule

//--- tb_pio_block.sv
`timescale 1ns/10ps

module tb_pio_block import pio_pkg::*; ();

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [1:0]  en = 2'b00;
  logic [9:0]  wrap_bottom = '0;
  logic [9:0]  wrap_top = '0;
  logic        prog_we = 1'b0;
  logic [4:0]  prog_addr = '0;
  logic [15:0] prog_data = '0;
  logic [63:0] tx_data = '0;
  logic [1:0]  tx_empty = 2'b11;
  logic [1:0]  rx_full = 2'b00;
  logic [1:0]  pull;
  logic [1:0]  push;
  logic [63:0] rx_data;
  logic [15:0] pins;
  logic [9:0]  pc;

  logic [15:0] img [32]; // Memory image shared with the model
  int          bot [2];
  int          top [2];
  int          n_exp [2];
  int          got [2];
  int          tx_hold [2];
  int          rx_hold [2];
  logic [1:0]  seen_bot = 2'b00;
  logic [7:0]  fin_pins [2];
  logic [31:0] tx_src [2][$];
  logic [31:0] tx_q [2][$];
  logic [31:0] exp_rx [2][$];
  logic        bp_en = 1'b0;
  int          checks;
  int          errors;
  int          timeouts;

  pio_block uut (.*);

  always #10 clk = ~clk;

  task automatic check_eq(input logic [31:0] got_v, input logic [31:0] exp_v,
                          input string what);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got_v, exp_v);
    end
  endtask

  function automatic logic [15:0] encode(input pio_op_e op, input int d, input int c,
                                         input int a);
    return {op, d[4:0], c[2:0], a[4:0]};
  endfunction

  function automatic int rand_delay(input logic dl);
    return dl ? int'($urandom % 8) : 0;
  endfunction

  function automatic logic busy(input int g);
    return en[g] && (got[g] < n_exp[g] || !seen_bot[g]);
  endfunction

  // Runs one machine until n_push words or the transmit words run out
  function automatic void pio_model(input int g, input int n_push);
    logic [31:0] x = '0;
    logic [31:0] y = '0;
    logic [31:0] isr = '0;
    logic [31:0] osr = '0;
    logic [31:0] src;
    logic [31:0] val;
    logic [31:0] mask;
    logic [7:0]  pv = '0;
    logic [15:0] w;
    logic [31:0] txm [$];
    int          pc_m = bot[g];
    int          n;
    int          ctl;
    int          arg;
    int          sel;
    int          steps = 0;
    logic        taken;
    txm = tx_src[g];
    exp_rx[g].delete();
    while (exp_rx[g].size() < n_push && steps < 4000) begin
      w     = img[pc_m];
      ctl   = int'(w[7:5]);
      arg   = int'(w[4:0]);
      n     = (arg == 0) ? 32 : arg;
      mask  = (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
      sel   = (w[15:13] == OP_MOV) ? arg % 8 : ctl;
      src   = (sel == 1) ? x : (sel == 2) ? y : (sel == 6) ? isr : (sel == 7) ? osr : 32'd0;
      taken = 1'b0;
      case (w[15:13])
        OP_JMP: begin
          taken = (ctl == 0) || (ctl == 1 && x == 0) || (ctl == 2 && x != 0) ||
                  (ctl == 3 && y == 0) || (ctl == 4 && y != 0) || (ctl == 5 && x != y);
          if (ctl == 2) x = x - 32'd1; // Decrements even when zero
          if (ctl == 4) y = y - 32'd1;
        end
        OP_IN: isr = (n == 32) ? src : ((isr << n) | (src & mask));
        OP_OUT: begin
          val = osr & mask;
          osr = (n == 32) ? 32'd0 : (osr >> n);
          if (ctl == 0) pv = val[7:0];
          else if (ctl == 1) x = val;
          else if (ctl == 2) y = val;
        end
        OP_PUSHPULL: begin
          if (ctl >= 4) begin
            if (txm.size() == 0) break;
            osr = txm.pop_front();
          end else begin
            exp_rx[g].push_back(isr);
            isr = '0;
          end
        end
        OP_MOV: begin
          val = arg[3] ? ~src : src;
          if (ctl == 1) x = val;
          else if (ctl == 2) y = val;
          else if (ctl == 6) isr = val;
          else if (ctl == 7) osr = val;
        end
        OP_SET: begin
          if (ctl == 0) pv = 8'(arg);
          else if (ctl == 1) x = arg;
          else if (ctl == 2) y = arg;
        end
        default: ;
      endcase
      pc_m = taken ? arg : (pc_m == top[g]) ? bot[g] : (pc_m + 1) % 32;
      steps++;
    end
    fin_pins[g] = pv;
  endfunction

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int g = 0; g < 2; g++) begin
        if (pull[g]) begin
          check_eq(tx_empty[g], 1'b0, $sformatf("sm%0d pull with tx_empty", g));
          if (tx_q[g].size() > 0) void'(tx_q[g].pop_front());
        end
        if (push[g]) begin
          check_eq(rx_full[g], 1'b0, $sformatf("sm%0d push with rx_full", g));
          if (exp_rx[g].size() == 0) begin
            errors++;
            $display("Machine %0d pushed a word that was not expected", g);
          end else begin
            check_eq(rx_data[g*32 +: 32], exp_rx[g].pop_front(), $sformatf("sm%0d rx_data", g));
            got[g]++;
          end
        end
        if (got[g] == n_exp[g] && pc[g*5 +: 5] == bot[g][4:0]) seen_bot[g] = 1'b1;
      end
    end
  end

  // Transmit head, back-pressure and receive stop after the last expected word
  always @(posedge clk) begin
    #2;
    for (int g = 0; g < 2; g++) begin
      if (bp_en && tx_hold[g] == 0 && $urandom % 5 == 0) tx_hold[g] = 1 + int'($urandom % 8);
      if (bp_en && rx_hold[g] == 0 && $urandom % 5 == 0) rx_hold[g] = 1 + int'($urandom % 8);
      tx_data[g*32 +: 32] = (tx_q[g].size() > 0) ? tx_q[g][0] : 32'd0;
      tx_empty[g] = (tx_q[g].size() == 0) || (tx_hold[g] > 0);
      rx_full[g]  = (got[g] >= n_exp[g]) || (rx_hold[g] > 0);
      if (tx_hold[g] > 0) tx_hold[g]--;
      if (rx_hold[g] > 0) rx_hold[g]--;
    end
  end

  task automatic setmov_program(input int g, input int base, input logic dl);
    img[base]     = encode(OP_SET, rand_delay(dl), 1, int'($urandom % 32));
    img[base + 1] = encode(OP_SET, rand_delay(dl), 2, int'($urandom % 32));
    img[base + 2] = encode(OP_MOV, rand_delay(dl), 6, 1);
    img[base + 3] = encode(OP_PUSHPULL, rand_delay(dl), 0, 0);
    img[base + 4] = encode(OP_MOV, rand_delay(dl), 6, 9);  // ISR gets ~X
    img[base + 5] = encode(OP_PUSHPULL, rand_delay(dl), 0, 0);
    img[base + 6] = encode(OP_MOV, rand_delay(dl), 6, 10); // ISR gets ~Y
    img[base + 7] = encode(OP_PUSHPULL, rand_delay(dl), 0, 0);
    bot[g]   = base;
    top[g]   = base + 7;
    n_exp[g] = 3;
    tx_src[g].delete();
  endtask

  task automatic count_program(input int g, input int base, input int n, input logic dl);
    img[base]     = encode(OP_SET, rand_delay(dl), 1, n);
    img[base + 1] = encode(OP_IN, rand_delay(dl), 1, 5);
    img[base + 2] = encode(OP_PUSHPULL, rand_delay(dl), 0, 0);
    img[base + 3] = encode(OP_JMP, rand_delay(dl), 2, base + 1); // Falls through at wrap_top
    bot[g]   = base;
    top[g]   = base + 3;
    n_exp[g] = n + 1;
    tx_src[g].delete();
  endtask

  task automatic shift_program(input int g, input int base, input int nw, input logic dl);
    img[base]     = encode(OP_PUSHPULL, rand_delay(dl), 4, 0);
    img[base + 1] = encode(OP_OUT, rand_delay(dl), 0, 8);
    img[base + 2] = encode(OP_OUT, rand_delay(dl), 1, 8);
    img[base + 3] = encode(OP_OUT, rand_delay(dl), 2, 16);
    img[base + 4] = encode(OP_MOV, rand_delay(dl), 6, 1);
    img[base + 5] = encode(OP_IN, rand_delay(dl), 2, 16);
    img[base + 6] = encode(OP_PUSHPULL, rand_delay(dl), 0, 0);
    bot[g]   = base;
    top[g]   = base + 6;
    n_exp[g] = nw;
    tx_src[g].delete();
    for (int i = 0; i < nw; i++) tx_src[g].push_back($urandom);
  endtask

  task automatic wait_done(input int max_cycles);
    int cyc;
    cyc = 0;
    while ((busy(0) || busy(1)) && cyc < max_cycles) begin
      @(negedge clk);
      #1;
      cyc++;
    end
    for (int g = 0; g < 2; g++) begin
      if (busy(g)) begin
        timeouts++;
        $display("Timeout: machine %0d stalled with %0d of %0d words received, pc %0d",
                 g, got[g], n_exp[g], pc[g*5 +: 5]);
      end
    end
  endtask

  // Reset, idle check, program load with machines off, then run
  task automatic run_programs(input logic [1:0] which, input logic bp);
    @(posedge clk);
    #2;
    en       = 2'b00;
    rst_n    = 1'b0;
    bp_en    = 1'b0;
    seen_bot = 2'b00;
    for (int g = 0; g < 2; g++) begin
      if (!which[g]) begin
        n_exp[g] = 0;
        tx_src[g].delete();
      end
      wrap_bottom[g*5 +: 5] = bot[g][4:0];
      wrap_top[g*5 +: 5]    = top[g][4:0];
      pio_model(g, n_exp[g]);
      tx_q[g]    = tx_src[g];
      got[g]     = 0;
      tx_hold[g] = 0;
      rx_hold[g] = 0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(pins, 16'd0, "idle pins");
    check_eq(push, 2'b00, "idle push");
    check_eq(pull, 2'b00, "idle pull");
    check_eq(pc, {bot[1][4:0], bot[0][4:0]}, "idle pc");
    bp_en = bp;
    for (int a = 0; a < 32; a++) begin
      @(posedge clk);
      #2;
      prog_we   = 1'b1;
      prog_addr = a[4:0];
      prog_data = img[a];
    end
    @(posedge clk);
    #2;
    prog_we = 1'b0;
    en      = which;
    wait_done(4000);
    for (int g = 0; g < 2; g++) begin
      if (which[g]) check_eq(pins[g*8 +: 8], fin_pins[g], $sformatf("sm%0d final pins", g));
    end
  endtask

  initial begin
    void'($urandom(37));
    for (int a = 0; a < 32; a++) begin
      img[a] = encode(OP_JMP, 0, 0, a); // Unused words hold the pc in place
    end
    setmov_program(1, 16, 1'b0);
    run_programs(2'b10, 1'b0);
    count_program(0, 3, 2 + int'($urandom % 6), 1'b0);
    run_programs(2'b01, 1'b0);
    shift_program(0, 8, 5, 1'b0);
    run_programs(2'b01, 1'b0);
    count_program(0, 0, 3 + int'($urandom % 5), 1'b1);
    setmov_program(1, 20, 1'b1);
    run_programs(2'b11, 1'b0);
    shift_program(0, 0, 6, 1'b0);
    shift_program(1, 16, 6, 1'b1);
    run_programs(2'b11, 1'b1);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- pio_block.f
+incdir+.
pio_pkg.sv
pio_fetch_if.sv
instr_mem.sv
fetch_arbiter.sv
pio_sm.sv
pio_block.sv
tb_pio_block.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_pio_block -f pio_block.f \
  && ./obj_dir/Vtb_pio_block > sim.log 2>&1 \
  || echo "Build or run error" >> sim.log
cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
